// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = icache_tb
FILELIST  = vlog.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: design/icache_ctrl.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      valid,
    input  cpu_req_t  req,
    output logic      addr_ok,
    output logic      data_ok,
    output line_t     rdata,
    output rnum_t     rnum,
    output logic      rd_req,
    output cpu_req_t  rd_addr,
    input  logic      rd_rdy,
    input  logic      ret_valid,
    input  line_t     ret_data,
    output logic      way_rd_en,
    output index_t    way_rd_index,
    output way_mask_t way_wr_mask,
    output refill_t   way_wr,
    input  way_rd_t   way_rd [`ICACHE_WAYS],
    output index_t    plru_index,
    output logic      plru_touch,
    output way_t      plru_touch_way,
    input  way_t      victim
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    cpu_req_t    rb;
    way_t        victim_q;
    way_mask_t   way_hit;
    way_t        hit_way;
    line_t       hit_line;
    logic        cache_hit;
    logic        accept;

    // Tag compare against the ways read last cycle
    always_comb begin
        way_hit  = '0;
        hit_way  = '0;
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = way_rd[w].valid && (way_rd[w].tag == rb.tag);
            if (way_hit[w]) begin
                hit_way  = way_t'(w);
                hit_line = hit_line | way_rd[w].line;
            end
        end
    end

    assign cache_hit = (state == LOOKUP) && (|way_hit);
    assign addr_ok   = valid && ((state == IDLE) || cache_hit);
    assign accept    = valid && addr_ok;

    // Request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            rb <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim_q <= '0;
        end else if (state == LOOKUP && !cache_hit) begin
            victim_q <= victim;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (accept) next_state = LOOKUP;
            LOOKUP:  next_state = cache_hit ? (accept ? LOOKUP : IDLE) : REPLACE;
            REPLACE: if (rd_rdy) next_state = REFILL;
            REFILL:  if (ret_valid) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // Way RAM side
    assign way_rd_en    = accept;
    assign way_rd_index = req.index;
    assign way_wr_mask  = (state == REFILL && ret_valid) ? way_mask_t'(1) << victim_q : '0;
    assign way_wr       = '{index: rb.index, tag: rb.tag, line: ret_data};

    // Victim is marked once, when memory takes the read
    assign plru_index     = rb.index;
    assign plru_touch     = cache_hit || (state == REPLACE && rd_rdy);
    assign plru_touch_way = (state == LOOKUP) ? hit_way : victim_q;

    assign rd_req  = (state == REPLACE);
    assign rd_addr = '{tag: rb.tag, index: rb.index, offset: '0};

    assign data_ok = cache_hit || (state == REFILL && ret_valid);
    assign rdata   = (state == REFILL) ? ret_data : hit_line;
    assign rnum    = rnum_t'(`ICACHE_LINE_W / `ICACHE_WORD_W)
                   - rnum_t'(rb.offset[`ICACHE_OFFSET_W-1:2]);

    // A line never lives in two ways of one set
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!resetn)
        (state == LOOKUP) |-> $onehot0(way_hit)
    ) else $error("multiple ways hit in set %0d", rb.index);

    // Line read stays requested, in REPLACE, until memory takes it
    a_rd_req_held: assert property (
        @(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && state == REPLACE
    ) else $error("rd_req dropped before rd_rdy");

endmodule

// File: design/icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_W-1:0]           tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]         index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0]        offset_t;
    typedef logic [`ICACHE_LINE_W-1:0]          line_t;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0]    way_t;
    typedef logic [`ICACHE_WAYS-1:0]            way_mask_t;
    typedef logic [`ICACHE_RNUM_W-1:0]          rnum_t;

    // Field order matches the byte address
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } cpu_req_t;

    // Write payload common to all ways
    typedef struct packed {
        index_t index;
        tag_t   tag;
        line_t  line;
    } refill_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        line_t line;
    } way_rd_t;

    typedef enum logic [1:0] {IDLE, LOOKUP, REPLACE, REFILL} ctrl_state_t;

endpackage

// File: design/icache_plru.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_plru
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  index_t index,
    input  logic   touch,
    input  way_t   touch_way,
    output way_t   victim
);

    logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] mru;

    way_mask_t cur_bits;
    way_mask_t touch_bit;
    way_mask_t next_bits;

    assign cur_bits  = mru[index];
    assign touch_bit = way_mask_t'(1) << touch_way;

    // When every other way is already marked, start a new round
    always_comb begin
        if ((cur_bits | touch_bit) == '1) begin
            next_bits = touch_bit;
        end else begin
            next_bits = cur_bits | touch_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mru <= '0;
        end else if (touch) begin
            mru[index] <= next_bits;
        end
    end

    // Lowest-numbered way not recently used
    always_comb begin
        victim = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!cur_bits[w]) begin
                victim = way_t'(w);
            end
        end
    end

    a_mru_never_full: assert property (
        @(posedge clk) disable iff (!resetn)
        touch |=> !(&mru[$past(index)])
    ) else $error("all MRU bits set in set %0d", $past(index));

endmodule

// File: design/icache_top.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     valid,
    input  cpu_req_t req,
    output logic     addr_ok,
    output logic     data_ok,
    output line_t    rdata,
    output rnum_t    rnum,
    output logic     rd_req,
    output cpu_req_t rd_addr,
    input  logic     rd_rdy,
    input  logic     ret_valid,
    input  line_t    ret_data
);

    logic      way_rd_en;
    index_t    way_rd_index;
    way_mask_t way_wr_mask;
    refill_t   way_wr;
    way_rd_t   way_rd [`ICACHE_WAYS];
    index_t    plru_index;
    logic      plru_touch;
    way_t      plru_touch_way;
    way_t      victim;

    icache_ctrl icache_ctrl_i (
        .clk            (clk),
        .resetn         (resetn),
        .valid          (valid),
        .req            (req),
        .addr_ok        (addr_ok),
        .data_ok        (data_ok),
        .rdata          (rdata),
        .rnum           (rnum),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_rdy         (rd_rdy),
        .ret_valid      (ret_valid),
        .ret_data       (ret_data),
        .way_rd_en      (way_rd_en),
        .way_rd_index   (way_rd_index),
        .way_wr_mask    (way_wr_mask),
        .way_wr         (way_wr),
        .way_rd         (way_rd),
        .plru_index     (plru_index),
        .plru_touch     (plru_touch),
        .plru_touch_way (plru_touch_way),
        .victim         (victim)
    );

    for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
        icache_way_ram icache_way_ram_i (
            .clk      (clk),
            .resetn   (resetn),
            .rd_en    (way_rd_en),
            .rd_index (way_rd_index),
            .wr_en    (way_wr_mask[g]),
            .wr       (way_wr),
            .rd       (way_rd[g])
        );
    end

    icache_plru icache_plru_i (
        .clk       (clk),
        .resetn    (resetn),
        .index     (plru_index),
        .touch     (plru_touch),
        .touch_way (plru_touch_way),
        .victim    (victim)
    );

endmodule

// File: design/icache_way_ram.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_way_ram
    import icache_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    rd_en,
    input  index_t  rd_index,
    input  logic    wr_en,
    input  refill_t wr,
    output way_rd_t rd
);

    tag_t                     tag_mem  [`ICACHE_SETS];
    line_t                    line_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]  valid_bits;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr.index]  <= wr.tag;
            line_mem[wr.index] <= wr.line;
        end
    end

    // Per-set valid bits
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
        end else if (wr_en) begin
            valid_bits[wr.index] <= 1'b1;
        end
    end

    // Synchronous read with data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd.valid <= valid_bits[rd_index];
            rd.tag   <= tag_mem[rd_index];
            rd.line  <= line_mem[rd_index];
        end
    end

    // Controller never refills a set while a lookup reads it
    a_no_rd_wr_same_set: assert property (
        @(posedge clk) disable iff (!resetn)
        !(rd_en && wr_en && rd_index == wr.index)
    ) else $error("way ram read and write to set %0d in one cycle", rd_index);

endmodule

// File: include/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Cache geometry
`define ICACHE_WAYS      4
`define ICACHE_SETS      128

// Address split
`define ICACHE_TAG_W     20
`define ICACHE_INDEX_W   7
`define ICACHE_OFFSET_W  5

// Line and word sizes
`define ICACHE_LINE_W    256
`define ICACHE_WORD_W    32

// Words from the offset to the end of a line
`define ICACHE_RNUM_W    4

`endif

// File: verif/icache_tb.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_tb
    import icache_pkg::*;
();

    logic     clk;
    logic     resetn;
    logic     valid;
    cpu_req_t req;
    logic     addr_ok;
    logic     data_ok;
    line_t    rdata;
    rnum_t    rnum;
    logic     rd_req;
    cpu_req_t rd_addr;
    logic     rd_rdy;
    logic     ret_valid;
    line_t    ret_data;

    int   errors;
    int   errors_at_start;
    int   tests;
    int   failed_tests;
    logic timed_out;

    // Reference model of tags, valid bits and MRU bits
    tag_t      ref_tag   [`ICACHE_SETS][`ICACHE_WAYS];
    logic      ref_valid [`ICACHE_SETS][`ICACHE_WAYS];
    way_mask_t ref_mru   [`ICACHE_SETS];

    icache_top icache_top_i (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rnum      (rnum),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Word w of a line holds the line address plus w
    function automatic line_t expected_line(input cpu_req_t a);
        line_t       l;
        logic [31:0] base;
        base = {a.tag, a.index, 5'b0};
        for (int w = 0; w < `ICACHE_LINE_W / `ICACHE_WORD_W; w++) begin
            l[w*`ICACHE_WORD_W +: `ICACHE_WORD_W] = base + w;
        end
        return l;
    endfunction

    initial begin : mem_responder
        cpu_req_t    line_addr;
        int unsigned delay;
        void'($urandom(32'hb85a_9dc7));
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (resetn && rd_req) begin
                line_addr = rd_addr;
                delay = $urandom_range(5, 0);
                repeat (delay) @(negedge clk);
                rd_rdy = 1'b1;
                @(negedge clk);
                rd_rdy = 1'b0;
                delay = $urandom_range(5, 0);
                repeat (delay) @(negedge clk);
                ret_valid = 1'b1;
                ret_data  = expected_line(line_addr);
                @(negedge clk);
                ret_valid = 1'b0;
            end
        end
    end

    task automatic check(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %0h, expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: the DUT gave no %s within the wait limit", what);
        errors++;
        timed_out = 1'b1;
        valid = 1'b0;
    endtask

    task automatic close_test(input string name);
        tests++;
        if (errors != errors_at_start) begin
            failed_tests++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
        errors_at_start = errors;
    endtask

    function automatic int find_way(input cpu_req_t r);
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (ref_valid[r.index][w] && ref_tag[r.index][w] == r.tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Lowest way whose MRU bit is clear
    function automatic way_t pick_victim(input index_t idx);
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (!ref_mru[idx][w]) begin
                return way_t'(w);
            end
        end
        return '0;
    endfunction

    function automatic void mark_used(input index_t idx, input way_t w);
        way_mask_t bits;
        bits = ref_mru[idx];
        bits[w] = 1'b1;
        if (bits == '1) begin
            bits = '0;
            bits[w] = 1'b1;
        end
        ref_mru[idx] = bits;
    endfunction

    function automatic void clear_model();
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            ref_mru[s] = '0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
    endfunction

    // One request through acceptance, lookup and any refill
    task automatic issue_request(input cpu_req_t r, output logic hit);
        cpu_req_t line_addr;
        int       way;
        int       n;
        logic     exp_hit;
        line_t    exp_line;
        rnum_t    exp_rnum;
        hit = 1'b0;
        if (timed_out) begin
            return;
        end
        line_addr = r;
        line_addr.offset = '0;
        exp_line = expected_line(r);
        exp_rnum = rnum_t'(8 - int'(r.offset[4:2]));
        way = find_way(r);
        exp_hit = (way >= 0);
        if (!exp_hit) begin
            way = int'(pick_victim(r.index));
            ref_tag[r.index][way]   = r.tag;
            ref_valid[r.index][way] = 1'b1;
        end
        mark_used(r.index, way_t'(way));
        @(negedge clk);
        valid = 1'b1;
        req   = r;
        #1;
        n = 0;
        while (!addr_ok) begin
            n = n + 1;
            if (n > 20) begin
                report_timeout("addr_ok");
                return;
            end
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        valid = 1'b0;
        #1;
        hit = data_ok;
        check("data_ok (lookup)", line_t'(data_ok), line_t'(exp_hit));
        check("rd_req (lookup)", line_t'(rd_req), '0);
        if (data_ok) begin
            check("rdata", rdata, exp_line);
            check("rnum", line_t'(rnum), line_t'(exp_rnum));
            @(negedge clk);
            #1;
            check("rd_req (after hit)", line_t'(rd_req), '0);
            return;
        end
        @(negedge clk);
        #1;
        check("rd_req", line_t'(rd_req), line_t'(1'b1));
        check("rd_addr", line_t'(rd_addr), line_t'(line_addr));
        n = 0;
        while (!data_ok) begin
            n = n + 1;
            if (n > 40) begin
                report_timeout("data_ok after the line read");
                return;
            end
            @(negedge clk);
            #1;
        end
        check("ret_valid (with data_ok)", line_t'(ret_valid), line_t'(1'b1));
        check("rdata", rdata, exp_line);
        check("rnum", line_t'(rnum), line_t'(exp_rnum));
    endtask

    task automatic reset_defaults();
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            #1;
            check("addr_ok", line_t'(addr_ok), '0);
            check("data_ok", line_t'(data_ok), '0);
            check("rd_req", line_t'(rd_req), '0);
        end
    endtask

    task automatic cold_then_hit();
        cpu_req_t r;
        logic     hit;
        r = '{tag: 20'h3a5c1, index: 7'd9, offset: 5'd12};
        issue_request(r, hit);
        check("cold miss hit flag", line_t'(hit), '0);
        issue_request(r, hit);
        check("repeat hit flag", line_t'(hit), line_t'(1'b1));
    endtask

    task automatic back_to_back_hits();
        cpu_req_t a;
        cpu_req_t b;
        logic     hit;
        a = '{tag: 20'h12345, index: 7'd20, offset: 5'd8};
        b = '{tag: 20'h6789a, index: 7'd21, offset: 5'd28};
        issue_request(a, hit);
        issue_request(b, hit);
        if (timed_out) begin
            return;
        end
        mark_used(a.index, way_t'(find_way(a)));
        mark_used(b.index, way_t'(find_way(b)));
        @(negedge clk);
        valid = 1'b1;
        req   = a;
        #1;
        check("addr_ok (first)", line_t'(addr_ok), line_t'(1'b1));
        @(negedge clk);
        req = b;
        #1;
        check("addr_ok (second)", line_t'(addr_ok), line_t'(1'b1));
        check("data_ok (first)", line_t'(data_ok), line_t'(1'b1));
        check("rdata (first)", rdata, expected_line(a));
        check("rnum (first)", line_t'(rnum), line_t'(4'd6));
        @(negedge clk);
        valid = 1'b0;
        #1;
        check("data_ok (second)", line_t'(data_ok), line_t'(1'b1));
        check("rdata (second)", rdata, expected_line(b));
        check("rnum (second)", line_t'(rnum), line_t'(4'd1));
    endtask

    // Four fills, two re-touches, a fifth tag, then every tag again
    task automatic set_replacement();
        int       seq [12] = '{0, 1, 2, 3, 1, 0, 4, 0, 1, 2, 3, 4};
        cpu_req_t r;
        logic     hit;
        for (int i = 0; i < 12; i++) begin
            r.tag    = tag_t'(seq[i] + 'h51000);
            r.index  = 7'd99;
            r.offset = 5'((i % 8) * 4);
            issue_request(r, hit);
        end
    endtask

    task automatic rnum_sweep();
        cpu_req_t r;
        logic     hit;
        for (int w = 0; w < 8; w++) begin
            r = '{tag: 20'h00777, index: 7'd50, offset: 5'(w * 4 + w % 4)};
            issue_request(r, hit);
        end
    endtask

    initial begin
        resetn          = 1'b0;
        valid           = 1'b0;
        req             = '0;
        errors          = 0;
        errors_at_start = 0;
        tests           = 0;
        failed_tests    = 0;
        timed_out       = 1'b0;
        clear_model();
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        reset_defaults();
        close_test("reset_defaults");
        cold_then_hit();
        close_test("cold_miss_then_hit");
        back_to_back_hits();
        close_test("back_to_back_hits");
        set_replacement();
        close_test("set_replacement");
        rnum_sweep();
        close_test("rnum_sweep");
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
design/icache_pkg.sv
design/icache_way_ram.sv
design/icache_plru.sv
design/icache_ctrl.sv
design/icache_top.sv
verif/icache_tb.sv
